/* Bender.yml */
package:
  name: rv_exec

sources:
  # Package first, then the interface, then the modules bottom up
  - design/rv_exec_pkg.sv
  - design/exec_op_if.sv
  - design/inst_decoder.sv
  - design/int_alu.sv
  - design/barrel_shifter.sv
  - design/writeback_merge.sv
  - design/rv_exec_core.sv
  - target: test
    files:
      - tests/rv_exec_checker.sv
      - tests/rv_exec_monitor.sv
      - tests/tb_rv_exec.sv

/* design/barrel_shifter.sv */
`timescale 1ns/10ps

module barrel_shifter (
	input  logic                         clk,
	exec_op_if.consumer                  op,
	output logic [rv_exec_pkg::XLEN-1:0] shift_result
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] shift_d;

	always_comb begin
		case (op.shift_op)
			SRL:     shift_d = op.opnd_a >> op.shift_amt;
			// Sign bit fills from the left
			SRA:     shift_d = $signed(op.opnd_a) >>> op.shift_amt;
			default: shift_d = op.opnd_a << op.shift_amt;
		endcase
	end

	// Runs alongside the ALU, merge stage picks which one to use
	always_ff @(posedge clk) begin
		if (op.op_valid) begin
			shift_result <= shift_d;
		end
	end

endmodule

/* design/exec_op_if.sv */
`timescale 1ns/10ps

interface exec_op_if;
	import rv_exec_pkg::*;

	// Strobe for one decoded operation
	logic op_valid;
	// ALU side
	alu_op_e alu_op;
	logic [XLEN-1:0] opnd_a;
	logic [XLEN-1:0] opnd_b;
	// Shifter side
	shift_op_e shift_op;
	logic [$clog2(XLEN)-1:0] shift_amt;
	// Write-back control
	wb_sel_e wb_sel;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic rd_wen;
	// Control transfer
	logic is_branch;
	logic [2:0] branch_funct;
	logic is_jal;
	logic is_jalr;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] imm;
	logic illegal;

	modport producer (
		output op_valid, alu_op, opnd_a, opnd_b, shift_op, shift_amt,
		output wb_sel, rd_addr, rd_wen, is_branch, branch_funct, is_jal, is_jalr,
		output pc, imm, illegal
	);

	modport consumer (
		input op_valid, alu_op, opnd_a, opnd_b, shift_op, shift_amt,
		input wb_sel, rd_addr, rd_wen, is_branch, branch_funct, is_jal, is_jalr,
		input pc, imm, illegal
	);

endinterface

/* design/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         inst_valid,
	input  logic [rv_exec_pkg::XLEN-1:0] inst,
	input  logic [rv_exec_pkg::XLEN-1:0] pc,
	input  logic [rv_exec_pkg::XLEN-1:0] rs1_data,
	input  logic [rv_exec_pkg::XLEN-1:0] rs2_data,
	exec_op_if.producer                  op
);
	import rv_exec_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic f7_zero;
	logic f7_alt;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_d;
	logic [XLEN-1:0] opnd_a_d;
	logic [XLEN-1:0] opnd_b_d;
	alu_op_e alu_op_d;
	shift_op_e shift_op_d;
	wb_sel_e wb_sel_d;
	logic legal;

	// Instruction fields
	assign opcode = opcode_e'(inst[6:0]);
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	// Only all-zero or bit 30 set are meaningful funct7 values here
	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);

	// Immediate formats, all sign-extended
	assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		legal      = 1'b1;
		imm_d      = '0;
		alu_op_d   = ADD;
		shift_op_d = SLL;
		wb_sel_d   = WB_NONE;
		case (opcode)
			OP, OP_IMM: begin
				if (opcode == OP_IMM) begin
					imm_d = imm_i;
				end
				wb_sel_d = WB_ALU;
				case (funct3)
					// SUB exists in register form only
					3'b000: alu_op_d = (opcode == OP && f7_alt) ? SUB : ADD;
					3'b001: begin
						wb_sel_d   = WB_SHIFT;
						shift_op_d = SLL;
						legal      = f7_zero;
					end
					3'b010: alu_op_d = SLT;
					3'b011: alu_op_d = SLTU;
					3'b100: alu_op_d = XOR;
					3'b101: begin
						wb_sel_d   = WB_SHIFT;
						shift_op_d = funct7[5] ? SRA : SRL;
						legal      = f7_zero | f7_alt;
					end
					3'b110: alu_op_d = OR;
					default: alu_op_d = AND;
				endcase
				// Register form allows bit 30 only on ADD/SUB and SRL/SRA
				if (opcode == OP &&
					!(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
					legal = 1'b0;
				end
			end
			LUI: begin
				imm_d    = imm_u;
				wb_sel_d = WB_IMM;
			end
			AUIPC: begin
				imm_d    = imm_u;
				wb_sel_d = WB_ALU;
			end
			BRANCH: begin
				imm_d = imm_b;
				// EQ/NE on the subtract, the rest on signed or unsigned less-than
				if (funct3[2]) begin
					alu_op_d = funct3[1] ? SLTU : SLT;
				end else begin
					alu_op_d = SUB;
				end
				legal = (funct3[2:1] != 2'b01);
			end
			JAL: begin
				imm_d    = imm_j;
				wb_sel_d = WB_LINK;
			end
			JALR: begin
				// Target rs1 + imm comes out of the ALU adder
				imm_d    = imm_i;
				wb_sel_d = WB_LINK;
				legal    = (funct3 == 3'b000);
			end
			default: legal = 1'b0;
		endcase
		// Illegal ops write nothing back
		if (!legal) begin
			wb_sel_d = WB_NONE;
		end
	end

	// Operand select
	assign opnd_a_d = (opcode == AUIPC) ? pc : rs1_data;
	assign opnd_b_d = (opcode == OP_IMM || opcode == AUIPC || opcode == JALR) ? imm_d : rs2_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			op.op_valid <= 1'b0;
		end else begin
			op.op_valid <= inst_valid;
		end
	end

	// Decoded payload, qualified downstream by op_valid
	always_ff @(posedge clk) begin
		op.alu_op       <= alu_op_d;
		op.opnd_a       <= opnd_a_d;
		op.opnd_b       <= opnd_b_d;
		op.shift_op     <= shift_op_d;
		// shamt and rs2 both sit in the low bits of operand b
		op.shift_amt    <= opnd_b_d[$clog2(XLEN)-1:0];
		op.wb_sel       <= wb_sel_d;
		op.rd_addr      <= rd;
		op.rd_wen       <= (wb_sel_d != WB_NONE) && (rd != '0);
		op.is_branch    <= legal && (opcode == BRANCH);
		op.branch_funct <= funct3;
		op.is_jal       <= legal && (opcode == JAL);
		op.is_jalr      <= legal && (opcode == JALR);
		op.pc           <= pc;
		op.imm          <= imm_d;
		op.illegal      <= !legal;
	end

endmodule

/* design/int_alu.sv */
`timescale 1ns/10ps

module int_alu (
	input  logic                         clk,
	exec_op_if.consumer                  op,
	output logic [rv_exec_pkg::XLEN-1:0] alu_result,
	output logic                         alu_zero,
	output logic                         alu_less
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] sum;
	logic [XLEN:0] diff_ext;
	logic lt_unsigned;
	logic lt_signed;
	logic less;
	logic [XLEN-1:0] result_d;

	assign sum = op.opnd_a + op.opnd_b;
	// One subtractor feeds SUB and both less-than flavours
	assign diff_ext = {1'b0, op.opnd_a} - {1'b0, op.opnd_b};
	// Borrow out means a < b unsigned
	assign lt_unsigned = diff_ext[XLEN];
	// Signs differ: the negative one is smaller
	assign lt_signed = (op.opnd_a[XLEN-1] != op.opnd_b[XLEN-1]) ?
		op.opnd_a[XLEN-1] : diff_ext[XLEN-1];
	assign less = (op.alu_op == SLTU) ? lt_unsigned : lt_signed;

	always_comb begin
		case (op.alu_op)
			SUB:     result_d = diff_ext[XLEN-1:0];
			AND:     result_d = op.opnd_a & op.opnd_b;
			OR:      result_d = op.opnd_a | op.opnd_b;
			XOR:     result_d = op.opnd_a ^ op.opnd_b;
			SLT,
			SLTU:    result_d = {{(XLEN-1){1'b0}}, less};
			default: result_d = sum;
		endcase
	end

	// Result and branch flags line up with the merge stage registers
	always_ff @(posedge clk) begin
		if (op.op_valid) begin
			alu_result <= result_d;
			alu_zero   <= (result_d == '0);
			alu_less   <= less;
		end
	end

endmodule

/* design/rv_exec_core.sv */
`timescale 1ns/10ps

module rv_exec_core (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               inst_valid,
	input  logic [rv_exec_pkg::XLEN-1:0]       inst,
	input  logic [rv_exec_pkg::XLEN-1:0]       pc,
	input  logic [rv_exec_pkg::XLEN-1:0]       rs1_data,
	input  logic [rv_exec_pkg::XLEN-1:0]       rs2_data,
	output logic                               result_valid,
	output logic                               rd_wen,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_addr,
	output logic [rv_exec_pkg::XLEN-1:0]       rd_data,
	output logic [rv_exec_pkg::XLEN-1:0]       next_pc,
	output logic                               branch_taken,
	output logic                               illegal_inst
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] alu_result;
	logic alu_zero;
	logic alu_less;
	logic [XLEN-1:0] shift_result;

	// Decoded operation shared by both units and the merge stage
	exec_op_if op_bus ();

	inst_decoder u_decoder (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.op         (op_bus)
	);

	int_alu u_alu (
		.clk        (clk),
		.op         (op_bus),
		.alu_result (alu_result),
		.alu_zero   (alu_zero),
		.alu_less   (alu_less)
	);

	barrel_shifter u_shifter (
		.clk          (clk),
		.op           (op_bus),
		.shift_result (shift_result)
	);

	// Results appear two edges after inst_valid
	writeback_merge u_merge (
		.clk          (clk),
		.rst          (rst),
		.op           (op_bus),
		.alu_result   (alu_result),
		.alu_zero     (alu_zero),
		.alu_less     (alu_less),
		.shift_result (shift_result),
		.result_valid (result_valid),
		.rd_wen       (rd_wen),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal_inst (illegal_inst)
	);

endmodule

/* design/rv_exec_pkg.sv */
package rv_exec_pkg;

	// Datapath and PC width
	localparam int XLEN = 32;
	// Register index width
	localparam int REG_ADDR_W = 5;
	// Sequential PC step
	localparam int INST_BYTES = 4;

	// Major opcodes kept on this path
	// Any other value decodes as illegal
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_e;

	// ALU operations
	// SUB and the set-less-than ops double as branch compares
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLTU
	} alu_op_e;

	// Shifter operations
	typedef enum logic [1:0] {
		SLL,
		SRL,
		SRA
	} shift_op_e;

	// Write-back data source
	typedef enum logic [2:0] {
		WB_ALU,
		WB_SHIFT,
		WB_IMM,
		WB_LINK,
		WB_NONE
	} wb_sel_e;

endpackage

/* design/writeback_merge.sv */
`timescale 1ns/10ps

module writeback_merge (
	input  logic                               clk,
	input  logic                               rst,
	exec_op_if.consumer                        op,
	input  logic [rv_exec_pkg::XLEN-1:0]       alu_result,
	input  logic                               alu_zero,
	input  logic                               alu_less,
	input  logic [rv_exec_pkg::XLEN-1:0]       shift_result,
	output logic                               result_valid,
	output logic                               rd_wen,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_addr,
	output logic [rv_exec_pkg::XLEN-1:0]       rd_data,
	output logic [rv_exec_pkg::XLEN-1:0]       next_pc,
	output logic                               branch_taken,
	output logic                               illegal_inst
);
	import rv_exec_pkg::*;

	logic valid_q;
	logic rd_wen_q;
	logic is_branch_q;
	logic is_jal_q;
	logic is_jalr_q;
	logic illegal_q;
	wb_sel_e wb_sel_q;
	logic [2:0] branch_funct_q;
	logic [REG_ADDR_W-1:0] rd_addr_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] imm_q;
	logic cond_met;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] link_pc;

	// Control flags, all qualified by op_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q     <= 1'b0;
			rd_wen_q    <= 1'b0;
			is_branch_q <= 1'b0;
			is_jal_q    <= 1'b0;
			is_jalr_q   <= 1'b0;
			illegal_q   <= 1'b0;
		end else begin
			valid_q     <= op.op_valid;
			rd_wen_q    <= op.op_valid & op.rd_wen;
			is_branch_q <= op.op_valid & op.is_branch;
			is_jal_q    <= op.op_valid & op.is_jal;
			is_jalr_q   <= op.op_valid & op.is_jalr;
			illegal_q   <= op.op_valid & op.illegal;
		end
	end

	// Same edge as the unit results
	always_ff @(posedge clk) begin
		wb_sel_q       <= op.wb_sel;
		branch_funct_q <= op.branch_funct;
		rd_addr_q      <= op.rd_addr;
		pc_q           <= op.pc;
		imm_q          <= op.imm;
	end

	// funct3[2] picks less-than over equal, funct3[0] inverts
	assign cond_met     = branch_funct_q[2] ? alu_less : alu_zero;
	assign branch_taken = is_branch_q & (cond_met ^ branch_funct_q[0]);

	// Shared target adder for branches and JAL
	assign target  = pc_q + imm_q;
	assign link_pc = pc_q + XLEN'(INST_BYTES);

	always_comb begin
		case (wb_sel_q)
			WB_ALU:   rd_data = alu_result;
			WB_SHIFT: rd_data = shift_result;
			WB_IMM:   rd_data = imm_q;
			WB_LINK:  rd_data = link_pc;
			default:  rd_data = '0;
		endcase
	end

	always_comb begin
		if (branch_taken || is_jal_q) begin
			next_pc = target;
		end else if (is_jalr_q) begin
			// rs1 + imm from the ALU, low bit dropped
			next_pc = {alu_result[XLEN-1:1], 1'b0};
		end else begin
			next_pc = link_pc;
		end
	end

	assign result_valid = valid_q;
	assign rd_wen       = rd_wen_q;
	assign rd_addr      = rd_addr_q;
	assign illegal_inst = illegal_q;

endmodule

/* flist.f */
design/rv_exec_pkg.sv
design/exec_op_if.sv
design/inst_decoder.sv
design/int_alu.sv
design/barrel_shifter.sv
design/writeback_merge.sv
design/rv_exec_core.sv
tests/rv_exec_checker.sv
tests/rv_exec_monitor.sv
tests/tb_rv_exec.sv

/* tests/rv_exec_checker.sv */
`timescale 1ns/10ps

module rv_exec_checker (
	input logic                               clk,
	input logic                               rst,
	input logic                               inst_valid,
	input logic                               result_valid,
	input logic                               rd_wen,
	input logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_addr,
	input logic [rv_exec_pkg::XLEN-1:0]       next_pc,
	input logic                               branch_taken,
	input logic                               illegal_inst
);
	// Failed assertions, read by the testbench at the end
	int fail_count = 0;

	// Fixed two-edge latency, both directions
	assert property (@(posedge clk) disable iff (rst) inst_valid |-> ##2 result_valid)
		else begin
			$error("result_valid did not follow inst_valid after two cycles");
			fail_count++;
		end
	assert property (@(posedge clk) disable iff (rst) result_valid |-> $past(inst_valid, 2))
		else begin
			$error("result_valid without an instruction two cycles earlier");
			fail_count++;
		end

	// Write-enable only inside a result
	assert property (@(posedge clk) disable iff (rst) rd_wen |-> result_valid)
		else begin
			$error("rd_wen high outside result_valid");
			fail_count++;
		end
	// x0 is never written
	assert property (@(posedge clk) disable iff (rst) rd_wen |-> (rd_addr != '0))
		else begin
			$error("rd_wen high with rd_addr zero");
			fail_count++;
		end

	// Illegal ops have no side effects
	assert property (@(posedge clk) disable iff (rst) illegal_inst |-> !rd_wen && !branch_taken)
		else begin
			$error("illegal_inst together with rd_wen or branch_taken");
			fail_count++;
		end
	// Halfword-aligned targets only
	assert property (@(posedge clk) disable iff (rst) result_valid |-> (next_pc[0] == 1'b0))
		else begin
			$error("next_pc bit 0 set");
			fail_count++;
		end

endmodule

/* tests/rv_exec_monitor.sv */
`timescale 1ns/10ps

module rv_exec_monitor (
	input logic                               clk,
	input logic                               rst,
	input logic                               inst_valid,
	input logic [rv_exec_pkg::XLEN-1:0]       inst,
	input logic [rv_exec_pkg::XLEN-1:0]       pc,
	input logic [rv_exec_pkg::XLEN-1:0]       rs1_data,
	input logic [rv_exec_pkg::XLEN-1:0]       rs2_data,
	input logic                               result_valid,
	input logic                               rd_wen,
	input logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_addr,
	input logic [rv_exec_pkg::XLEN-1:0]       rd_data,
	input logic [rv_exec_pkg::XLEN-1:0]       next_pc,
	input logic                               branch_taken,
	input logic                               illegal_inst
);
	import rv_exec_pkg::*;

	// One expected result per accepted instruction
	typedef struct packed {
		logic                  wen;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
		logic [XLEN-1:0]       npc;
		logic                  taken;
		logic                  ill;
	} exp_t;

	exp_t exp_q[$];
	exp_t cur;
	int error_count = 0;
	int result_count = 0;

	// Expected outcome straight from the RV32I rules
	function automatic exp_t ref_model(input logic [XLEN-1:0] word, pc_in, rs1, rs2);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [XLEN-1:0] imm_i;
		logic [XLEN-1:0] imm_b;
		logic [XLEN-1:0] imm_u;
		logic [XLEN-1:0] imm_j;
		logic [XLEN-1:0] opnd_b;
		logic [4:0] shamt;
		logic legal;
		logic writes;
		exp_t e;
		opc    = word[6:0];
		f3     = word[14:12];
		f7     = word[31:25];
		imm_i  = {{20{word[31]}}, word[31:20]};
		imm_b  = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
		imm_u  = {word[31:12], 12'h000};
		imm_j  = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		opnd_b = (opc == OP_IMM) ? imm_i : rs2;
		shamt  = opnd_b[4:0];
		e      = '0;
		e.rd   = word[11:7];
		e.npc  = pc_in + INST_BYTES;
		legal  = 1'b1;
		writes = 1'b0;
		case (opc)
			OP, OP_IMM: begin
				writes = 1'b1;
				case (f3)
					3'b000: e.data = (opc == OP && f7 == 7'h20) ? rs1 - opnd_b : rs1 + opnd_b;
					3'b001: e.data = rs1 << shamt;
					3'b010: e.data = ($signed(rs1) < $signed(opnd_b)) ? 32'd1 : 32'd0;
					3'b011: e.data = (rs1 < opnd_b) ? 32'd1 : 32'd0;
					3'b100: e.data = rs1 ^ opnd_b;
					3'b101: begin
						// Kept out of a ?: so the shift stays signed
						if (f7[5]) begin
							e.data = $signed(rs1) >>> shamt;
						end else begin
							e.data = rs1 >> shamt;
						end
					end
					3'b110: e.data = rs1 | opnd_b;
					default: e.data = rs1 & opnd_b;
				endcase
				if (opc == OP) begin
					legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
				end else if (f3 == 3'b001) begin
					legal = (f7 == 7'h00);
				end else if (f3 == 3'b101) begin
					legal = (f7 == 7'h00) || (f7 == 7'h20);
				end
			end
			LUI: begin
				writes = 1'b1;
				e.data = imm_u;
			end
			AUIPC: begin
				writes = 1'b1;
				e.data = pc_in + imm_u;
			end
			BRANCH: begin
				case (f3)
					3'b000: e.taken = (rs1 == rs2);
					3'b001: e.taken = (rs1 != rs2);
					3'b100: e.taken = ($signed(rs1) < $signed(rs2));
					3'b101: e.taken = ($signed(rs1) >= $signed(rs2));
					3'b110: e.taken = (rs1 < rs2);
					3'b111: e.taken = (rs1 >= rs2);
					default: legal = 1'b0;
				endcase
				if (e.taken) begin
					e.npc = pc_in + imm_b;
				end
			end
			JAL: begin
				writes = 1'b1;
				e.data = pc_in + INST_BYTES;
				e.npc  = pc_in + imm_j;
			end
			JALR: begin
				legal  = (f3 == 3'b000);
				writes = 1'b1;
				e.data = pc_in + INST_BYTES;
				e.npc  = (rs1 + imm_i) & ~32'd1;
			end
			default: legal = 1'b0;
		endcase
		// No side effects for anything illegal
		if (!legal) begin
			writes  = 1'b0;
			e.taken = 1'b0;
			e.npc   = pc_in + INST_BYTES;
		end
		e.wen = writes && (e.rd != '0);
		e.ill = !legal;
		return e;
	endfunction

	task automatic check_field(input string name, input logic [XLEN-1:0] exp_val, act_val);
		if (act_val !== exp_val) begin
			$display("CHECK FAILED at %0t: %s expected 0x%08h actual 0x%08h",
				$time, name, exp_val, act_val);
			error_count++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			exp_q.delete();
		end else begin
			// Oldest outstanding instruction first
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: unexpected result with no instruction outstanding",
						$time);
					error_count++;
				end else begin
					cur = exp_q.pop_front();
					check_field("rd_wen", cur.wen, rd_wen);
					check_field("branch_taken", cur.taken, branch_taken);
					check_field("illegal_inst", cur.ill, illegal_inst);
					check_field("next_pc", cur.npc, next_pc);
					// Address and data only matter on a write
					if (cur.wen) begin
						check_field("rd_addr", cur.rd, rd_addr);
						check_field("rd_data", cur.data, rd_data);
					end
				end
				result_count++;
			end
			if (inst_valid) begin
				exp_q.push_back(ref_model(inst, pc, rs1_data, rs2_data));
			end
		end
	end

endmodule

/* tests/tb_rv_exec.sv */
`timescale 1ns/10ps

module tb_rv_exec;
	import rv_exec_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RTYPE = 70;
	localparam int N_SHIFT = 48;
	localparam int N_IMM = 64;
	localparam int N_BRANCH = 60;
	localparam int N_JUMP = 32;
	localparam int N_MIX = 240;
	localparam int TOTAL_INSTS = N_RTYPE + N_SHIFT + N_IMM + N_BRANCH + N_JUMP + N_MIX;
	// Idle and drain cycles between tests plus slack
	localparam int MARGIN_CYCLES = 100;

	// funct3 tables where ADD and SUB share 000
	localparam logic [2:0] R_F3 [0:6] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b011};
	localparam logic [2:0] I_F3 [0:5] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
	// BEQ BNE BLT BGE BLTU BGEU
	localparam logic [2:0] B_F3 [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	logic clk;
	logic rst;
	logic inst_valid;
	logic [XLEN-1:0] inst;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic result_valid;
	logic rd_wen;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic [XLEN-1:0] rd_data;
	logic [XLEN-1:0] next_pc;
	logic branch_taken;
	logic illegal_inst;

	logic [31:0] rng_state;
	int issued;
	int tests_run;
	int errs_start;

	rv_exec_core dut (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.pc           (pc),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.result_valid (result_valid),
		.rd_wen       (rd_wen),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal_inst (illegal_inst)
	);

	rv_exec_monitor mon (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.pc           (pc),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.result_valid (result_valid),
		.rd_wen       (rd_wen),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal_inst (illegal_inst)
	);

	// Port-level assertions on the core
	bind rv_exec_core rv_exec_checker chk (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.result_valid (result_valid),
		.rd_wen       (rd_wen),
		.rd_addr      (rd_addr),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal_inst (illegal_inst)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int total_errors();
		return mon.error_count + dut.chk.fail_count;
	endfunction

	// Every eighth rd is x0
	function automatic logic [4:0] pick_rd(input int i);
		return (i % 8 == 3) ? 5'd0 : 5'(next_rand());
	endfunction

	// Encoders with random register source fields
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] opc);
		logic [31:0] r;
		r = next_rand();
		return {f7, r[9:5], r[4:0], f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] opc);
		logic [31:0] r;
		r = next_rand();
		return {imm, r[4:0], f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
		logic [31:0] r;
		r = next_rand();
		return {imm[12], imm[10:5], r[9:5], r[4:0], f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	// One instruction per rising edge with a word-aligned PC
	task automatic issue(input logic [31:0] word, input logic [XLEN-1:0] a, b);
		@(posedge clk);
		inst_valid <= 1'b1;
		inst       <= word;
		pc         <= next_rand() & 32'hFFFF_FFFC;
		rs1_data   <= a;
		rs2_data   <= b;
		issued++;
	endtask

	// Drop the strobe and wait for the pipe to drain
	task automatic end_test(input string name, input int n);
		@(posedge clk);
		inst_valid <= 1'b0;
		do @(negedge clk); while (mon.result_count < issued);
		tests_run++;
		$display("Test %0d %s: %0d instructions, %0d errors",
			tests_run, name, n, total_errors() - errs_start);
		errs_start = total_errors();
	endtask

	task automatic test_rtype(input int n);
		for (int i = 0; i < n; i++) begin
			issue(enc_r((i % 7 == 1) ? 7'h20 : 7'h00, R_F3[i % 7], pick_rd(i), OP),
				next_rand(), next_rand());
		end
	endtask

	task automatic test_shift(input int n);
		int k;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] a;
		logic [31:0] word;
		for (int i = 0; i < n; i++) begin
			k  = i % 6;
			f3 = (k % 3 == 0) ? 3'b001 : 3'b101;
			f7 = (k % 3 == 2) ? 7'h20 : 7'h00;
			// Negative rs1 on every other round
			a  = next_rand();
			if ((i / 6) % 2 == 1) begin
				a[31] = 1'b1;
			end
			if (k < 3) begin
				word = enc_r(f7, f3, pick_rd(i), OP);
			end else begin
				word = enc_i({f7, 5'(next_rand())}, f3, pick_rd(i), OP_IMM);
			end
			issue(word, a, next_rand());
		end
	endtask

	task automatic test_imm(input int n);
		int k;
		int j;
		logic [31:0] word;
		for (int i = 0; i < n; i++) begin
			k = i % 8;
			// x0 moves to a different op each round of eight
			j = i + i / 8;
			if (k < 6) begin
				word = enc_i(12'(next_rand()), I_F3[k], pick_rd(j), OP_IMM);
			end else begin
				word = enc_u(20'(next_rand()), pick_rd(j), (k == 6) ? LUI : AUIPC);
			end
			issue(word, next_rand(), next_rand());
		end
	endtask

	task automatic test_branch(input int n);
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < n; i++) begin
			// Equal operands for one round of six and random the next
			a = next_rand();
			b = ((i / 6) % 2 == 0) ? a : next_rand();
			issue(enc_b(13'(next_rand()), B_F3[i % 6]), a, b);
		end
	endtask

	task automatic test_jump(input int n);
		logic [31:0] word;
		for (int i = 0; i < n; i++) begin
			if (i % 2 == 0) begin
				word = enc_j(21'(next_rand()), pick_rd(i));
			end else begin
				word = enc_i(12'(next_rand()), 3'b000, pick_rd(i), JALR);
			end
			issue(word, next_rand(), next_rand());
		end
	endtask

	task automatic test_mix(input int n);
		logic [31:0] r;
		logic [31:0] word;
		for (int i = 0; i < n; i++) begin
			r = next_rand();
			case (r[2:0])
				3'd0: word = enc_r(7'h00, r[8:6], pick_rd(i), OP);
				// Alternate funct7 is illegal outside SUB and SRA
				3'd1: word = enc_r(7'h20, r[8:6], pick_rd(i), OP);
				3'd2: word = enc_i(r[31:20], r[8:6], pick_rd(i), OP_IMM);
				3'd3: word = enc_b(r[31:19], r[8:6]);
				3'd4: word = enc_j(r[31:11], pick_rd(i));
				3'd5: word = enc_i(r[31:20], r[8:6], pick_rd(i), JALR);
				3'd6: word = enc_u(r[31:12], pick_rd(i), r[9] ? LUI : AUIPC);
				// Raw word that mostly holds an illegal opcode
				default: word = next_rand();
			endcase
			issue(word, next_rand(), next_rand());
		end
	endtask

	// Watchdog sized from the instruction count
	initial begin
		#((RESET_CYCLES + TOTAL_INSTS + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: only %0d of %0d results seen before the watchdog expired",
			mon.result_count, issued);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		pc         = '0;
		rs1_data   = '0;
		rs2_data   = '0;
		rng_state  = 32'd76347;
		issued     = 0;
		tests_run  = 0;
		errs_start = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);

		test_rtype(N_RTYPE);
		end_test("R-type ALU", N_RTYPE);
		test_shift(N_SHIFT);
		end_test("shifts", N_SHIFT);
		test_imm(N_IMM);
		end_test("I-type, LUI, AUIPC", N_IMM);
		test_branch(N_BRANCH);
		end_test("branches", N_BRANCH);
		test_jump(N_JUMP);
		end_test("JAL and JALR", N_JUMP);
		test_mix(N_MIX);
		end_test("back-to-back mix", N_MIX);

		$display("Done: %0d tests, %0d results checked, %0d errors",
			tests_run, mon.result_count, total_errors());
		if (total_errors() == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
